/* bench/icache_refill_model.sv */
// answers one miss at a time: set_tag packet, data packet, then completion
// samples the request mid-cycle, after the bench has driven its inputs
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_refill_model
  import icache_addr_pkg::*;
  import icache_fill_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  miss_req_s  cache_req_i,
  input  logic       cache_req_v_i,
  input  miss_meta_s meta_i,
  output tag_pkt_s   tag_pkt_o,
  output logic       tag_pkt_v_o,
  input  logic       tag_pkt_ready_i,
  output data_pkt_s  data_pkt_o,
  output logic       data_pkt_v_o,
  input  logic       data_pkt_ready_i,
  output logic       complete_o
);

  // memory contents: any block word is a function of block address and word
  function automatic dword_t mem_word(paddr_u a, int w);
    logic [34:0] blk;
    logic [1:0] ws;
    blk = {a.cache.tag, a.cache.index};
    ws = w[1:0];
    return {~{ws, blk[29:0]}, {blk[29:0], ws}};
  endfunction

  initial begin : serve
    paddr_u a;
    way_id_t w;
    tag_pkt_v_o = 1'b0;
    data_pkt_v_o = 1'b0;
    complete_o = 1'b0;
    tag_pkt_o = '0;
    data_pkt_o = '0;
    forever begin
      @(negedge clk_i);
      #2;
      if (!reset_i && cache_req_v_i) begin
        a = cache_req_i.addr;
        // metadata arrives one cycle after the request
        @(negedge clk_i);
        #2;
        w = meta_i.repl_way;
        tag_pkt_o.op = e_tag_set_tag;
        tag_pkt_o.index = a.cache.index;
        tag_pkt_o.way = w;
        tag_pkt_o.tag = a.cache.tag;
        tag_pkt_v_o = 1'b1;
        #1;
        while (!tag_pkt_ready_i) begin
          @(negedge clk_i);
          #3;
        end
        @(negedge clk_i);
        tag_pkt_v_o = 1'b0;
        data_pkt_o.index = a.cache.index;
        data_pkt_o.way = w;
        for (int k = 0; k < `ICACHE_BLOCK_WORDS; k++) begin
          data_pkt_o.data[k] = mem_word(a, k);
        end
        data_pkt_v_o = 1'b1;
        #1;
        while (!data_pkt_ready_i) begin
          @(negedge clk_i);
          #1;
        end
        @(negedge clk_i);
        data_pkt_v_o = 1'b0;
        complete_o = 1'b1;
        @(negedge clk_i);
        complete_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/icache_tb.sv */
// serial fetches with replay after a miss, reference model of valid, tag and LRU bits
// concurrent assertions compare the DUT outputs with the model
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_tb
  import icache_addr_pkg::*;
  import icache_fill_pkg::*;
();

  localparam int FETCH_BUDGET = 160;

  logic clk, reset;
  logic [`ICACHE_VADDR_W-1:0] vaddr;
  logic vaddr_v, vaddr_ready, ptag_v, poison;
  ptag_t ptag;
  logic [`ICACHE_INSTR_W-1:0] data;
  logic data_v, miss, req_v, req_ready, meta_v, complete;
  miss_req_s req;
  miss_meta_s meta;
  tag_pkt_s tag_pkt, model_tag_pkt, tb_tag_pkt;
  logic tag_pkt_v, model_tag_v, tb_tag_v, tag_pkt_ready;
  data_pkt_s data_pkt;
  logic data_pkt_v, data_pkt_ready;

  // reference state
  ptag_t ref_tag [`ICACHE_SETS][`ICACHE_WAYS];
  logic ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
  logic [2:0] ref_lru [`ICACHE_SETS];

  logic tv_check, quiet_check, exp_hit, rand_ready;
  logic [`ICACHE_INSTR_W-1:0] exp_data;
  paddr_u exp_addr;
  way_id_t exp_victim;
  int errors;

  assign tag_pkt_v = model_tag_v | tb_tag_v;
  assign tag_pkt = model_tag_v ? model_tag_pkt : tb_tag_pkt;

  icache uut (
    .clk_i(clk), .reset_i(reset),
    .vaddr_i(vaddr), .vaddr_v_i(vaddr_v), .vaddr_ready_o(vaddr_ready),
    .ptag_i(ptag), .ptag_v_i(ptag_v), .poison_i(poison),
    .data_o(data), .data_v_o(data_v), .miss_o(miss),
    .cache_req_o(req), .cache_req_v_o(req_v), .cache_req_ready_i(req_ready),
    .cache_req_metadata_o(meta), .cache_req_metadata_v_o(meta_v),
    .cache_req_complete_i(complete),
    .tag_pkt_i(tag_pkt), .tag_pkt_v_i(tag_pkt_v), .tag_pkt_ready_o(tag_pkt_ready),
    .data_pkt_i(data_pkt), .data_pkt_v_i(data_pkt_v), .data_pkt_ready_o(data_pkt_ready)
  );

  icache_refill_model refill (
    .clk_i(clk), .reset_i(reset),
    .cache_req_i(req), .cache_req_v_i(req_v), .meta_i(meta),
    .tag_pkt_o(model_tag_pkt), .tag_pkt_v_o(model_tag_v), .tag_pkt_ready_i(tag_pkt_ready),
    .data_pkt_o(data_pkt), .data_pkt_v_o(data_pkt_v), .data_pkt_ready_i(data_pkt_ready),
    .complete_o(complete)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // model follows accepted tag packets
  always @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        ref_lru[s] = '0;
        for (int i = 0; i < `ICACHE_WAYS; i++) ref_valid[s][i] = 1'b0;
      end
    end else if (tag_pkt_v && tag_pkt_ready) begin
      case (tag_pkt.op)
        e_tag_clear_set: begin
          for (int i = 0; i < `ICACHE_WAYS; i++) ref_valid[tag_pkt.index][i] = 1'b0;
        end
        e_tag_invalidate: ref_valid[tag_pkt.index][tag_pkt.way] = 1'b0;
        e_tag_set_tag: begin
          ref_valid[tag_pkt.index][tag_pkt.way] = 1'b1;
          ref_tag[tag_pkt.index][tag_pkt.way] = tag_pkt.tag;
        end
        default: ;
      endcase
    end
  end

  function automatic dword_t expected_dword(paddr_u a, int w);
    logic [34:0] blk;
    logic [1:0] ws;
    blk = {a.cache.tag, a.cache.index};
    ws = w[1:0];
    return {~{ws, blk[29:0]}, {blk[29:0], ws}};
  endfunction

  function automatic paddr_u make_addr(ptag_t t, set_index_t s, word_sel_t w, logic [2:0] b);
    paddr_u a;
    a.cache.tag = t;
    a.cache.index = s;
    a.cache.word = w;
    a.cache.byte_sel = b;
    return a;
  endfunction

  // lowest invalid way, otherwise follow the tree bits
  function automatic way_id_t predict_victim(set_index_t s);
    way_id_t v;
    logic found;
    found = 1'b0;
    v = '0;
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      if (!found && !ref_valid[s][i]) begin
        found = 1'b1;
        v = way_id_t'(i);
      end
    end
    if (!found) begin
      if (ref_lru[s][0]) begin
        v = {1'b1, ref_lru[s][2]};
      end else begin
        v = {1'b0, ref_lru[s][1]};
      end
    end
    return v;
  endfunction

  task automatic drive_ready();
    req_ready = rand_ready ? 1'($urandom) : 1'b1;
  endtask

  task automatic run_fetch(input paddr_u a, input logic psn, output logic hit);
    logic found;
    way_id_t way;
    dword_t dw;
    @(negedge clk);
    drive_ready();
    vaddr = {27'($urandom), a.page.offset};
    vaddr_v = 1'b1;
    ptag = a.page.ptag;
    #1;
    while (!vaddr_ready) begin
      @(negedge clk);
      drive_ready();
      #1;
    end
    // TL cycle
    @(negedge clk);
    vaddr_v = 1'b0;
    ptag_v = 1'b1;
    poison = psn;
    drive_ready();
    // TV cycle
    @(negedge clk);
    ptag_v = 1'b0;
    poison = 1'b0;
    drive_ready();
    found = 1'b0;
    way = '0;
    for (int i = `ICACHE_WAYS-1; i >= 0; i--) begin
      if (ref_valid[a.cache.index][i] && ref_tag[a.cache.index][i] == a.cache.tag) begin
        found = 1'b1;
        way = way_id_t'(i);
      end
    end
    dw = expected_dword(a, int'(a.cache.word));
    exp_data = a.cache.byte_sel[2] ? dw[63:32] : dw[31:0];
    exp_hit = found;
    exp_addr = a;
    exp_victim = predict_victim(a.cache.index);
    if (psn) quiet_check = 1'b1;
    else tv_check = 1'b1;
    if (found && !psn) begin
      // root and pair bit point away from the accessed way
      if (way < 2'd2) begin
        ref_lru[a.cache.index][0] = 1'b1;
        ref_lru[a.cache.index][1] = (way == 2'd0);
      end else begin
        ref_lru[a.cache.index][0] = 1'b0;
        ref_lru[a.cache.index][2] = (way == 2'd2);
      end
    end
    @(negedge clk);
    tv_check = 1'b0;
    quiet_check = 1'b0;
    hit = found && !psn;
  endtask

  task automatic fetch_until_hit(input paddr_u a);
    logic h;
    int n;
    h = 1'b0;
    n = 0;
    while (!h && n < 16) begin
      run_fetch(a, 1'b0, h);
      n++;
    end
    if (!h) begin
      errors++;
      $display("fetch to %h never hit after refills", a);
    end
  endtask

  task automatic send_tag_pkt(tag_op_e op, set_index_t s, way_id_t w, ptag_t t);
    @(negedge clk);
    tb_tag_pkt.op = op;
    tb_tag_pkt.index = s;
    tb_tag_pkt.way = w;
    tb_tag_pkt.tag = t;
    tb_tag_v = 1'b1;
    #1;
    while (!tag_pkt_ready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    tb_tag_v = 1'b0;
  endtask

  a_hit_miss: assert property (@(posedge clk) disable iff (reset)
    tv_check |-> data_v == exp_hit && miss == !exp_hit)
    else begin
      errors++;
      $display("mismatch hit_miss: expected hit %0b, actual data_v %0b miss %0b",
               exp_hit, data_v, miss);
    end

  a_data: assert property (@(posedge clk) disable iff (reset)
    tv_check && exp_hit |-> data == exp_data)
    else begin
      errors++;
      $display("mismatch data: expected %h, actual %h", exp_data, data);
    end

  a_poison: assert property (@(posedge clk) disable iff (reset)
    quiet_check |-> !data_v && !miss && !req_v)
    else begin
      errors++;
      $display("poisoned fetch produced a result, a miss or a request");
    end

  a_req_addr: assert property (@(posedge clk) disable iff (reset)
    req_v |-> req.addr == exp_addr)
    else begin
      errors++;
      $display("mismatch req_addr: expected %h, actual %h", exp_addr, req.addr);
    end

  a_meta: assert property (@(posedge clk) disable iff (reset)
    req_v |=> meta_v && meta.repl_way == exp_victim)
    else begin
      errors++;
      $display("mismatch victim: expected %0d, actual %0d (valid %0b)",
               exp_victim, meta.repl_way, meta_v);
    end

  a_backpressure: assert property (@(posedge clk) disable iff (reset)
    !req_ready |-> !vaddr_ready && !req_v)
    else begin
      errors++;
      $display("fetch ready or request high while request ready is low");
    end

  a_pkt_ready: assert property (@(posedge clk) disable iff (reset)
    vaddr_v && vaddr_ready |-> !tag_pkt_ready && !data_pkt_ready)
    else begin
      errors++;
      $display("packet ready high in a cycle that accepts a fetch");
    end

  initial begin
    #(FETCH_BUDGET * 40 * 20 + 400);
    $display("watchdog expired before the tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : main
    logic h;
    paddr_u a;
    void'($urandom(32'h73c7));
    reset = 1'b1;
    vaddr = '0;
    vaddr_v = 1'b0;
    ptag = '0;
    ptag_v = 1'b0;
    poison = 1'b0;
    req_ready = 1'b1;
    tb_tag_pkt = '0;
    tb_tag_v = 1'b0;
    tv_check = 1'b0;
    quiet_check = 1'b0;
    exp_hit = 1'b0;
    exp_data = '0;
    exp_addr = '0;
    exp_victim = '0;
    rand_ready = 1'b0;
    errors = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // cold miss, refill, then hits on other words of the block
    a = make_addr(28'h0000123, 7'd3, 2'd2, 3'd4);
    run_fetch(a, 1'b0, h);
    fetch_until_hit(a);
    run_fetch(make_addr(28'h0000123, 7'd3, 2'd1, 3'd0), 1'b0, h);

    // fill all four ways of set 9, random hits, then a fifth tag evicts
    for (int i = 0; i < 4; i++) fetch_until_hit(make_addr(ptag_t'(32'h200 + i), 7'd9, 2'd0, 3'd0));
    repeat (12) begin
      run_fetch(make_addr(ptag_t'(32'h200 + $urandom % 4), 7'd9, 2'($urandom), 3'($urandom)),
                1'b0, h);
    end
    fetch_until_hit(make_addr(28'h00002f0, 7'd9, 2'd3, 3'd4));

    // invalidate way 1 and refetch its tag
    a = make_addr(ref_tag[9][1], 7'd9, 2'd1, 3'd4);
    send_tag_pkt(e_tag_invalidate, 7'd9, 2'd1, '0);
    fetch_until_hit(a);

    // poisoned fetches to a hit and to a miss give nothing
    run_fetch(make_addr(28'h0000123, 7'd3, 2'd2, 3'd0), 1'b1, h);
    run_fetch(make_addr(28'h0000456, 7'd3, 2'd0, 3'd0), 1'b1, h);

    // random back-pressure on the miss request port
    rand_ready = 1'b1;
    repeat (10) begin
      fetch_until_hit(make_addr(ptag_t'(32'h300 + $urandom % 6), 7'($urandom % 4),
                                2'($urandom), 3'($urandom)));
    end
    rand_ready = 1'b0;
    req_ready = 1'b1;
    repeat (4) @(negedge clk);

    $display("fetch checks complete, errors: %0d", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* include/icache_config.svh */
// geometry of the instruction cache
// index and block offset must together fill the page offset exactly,
// so that the cache tag and the physical page tag are the same bits
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// associativity, also the number of data banks
`define ICACHE_WAYS 4
`define ICACHE_SETS 128

// dwords per block, one per bank
`define ICACHE_BLOCK_WORDS 4
`define ICACHE_DWORD_W 64
`define ICACHE_INSTR_W 32

// address widths
`define ICACHE_PADDR_W 40
`define ICACHE_VADDR_W 39
`define ICACHE_PAGE_OFFSET_W 12

`endif

/* list.f */
+incdir+include
source/icache_addr_pkg.sv
source/icache_fill_pkg.sv
source/icache_tag_array.sv
source/icache_data_banks.sv
source/icache_plru.sv
source/icache_miss_ctrl.sv
source/icache.sv
bench/icache_refill_model.sv
bench/icache_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it into sim.log and checks the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module icache_tb -o icache_sim \
  > build.log 2>&1 \
  && ./obj_dir/icache_sim > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* source/icache.sv */
// 4-way VIPT instruction cache, cached fetches only
// TL reads the arrays, TV compares against the physical tag from the core
// a fetch in TV advances every cycle, the core must replay after a miss
// packets are accepted only in cycles without a fetch acceptance
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache
  import icache_addr_pkg::*;
  import icache_fill_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [`ICACHE_VADDR_W-1:0] vaddr_i,
  input  logic                       vaddr_v_i,
  output logic                       vaddr_ready_o,
  input  ptag_t                      ptag_i,
  input  logic                       ptag_v_i,
  input  logic                       poison_i,
  output logic [`ICACHE_INSTR_W-1:0] data_o,
  output logic                       data_v_o,
  output logic                       miss_o,
  output miss_req_s                  cache_req_o,
  output logic                       cache_req_v_o,
  input  logic                       cache_req_ready_i,
  output miss_meta_s                 cache_req_metadata_o,
  output logic                       cache_req_metadata_v_o,
  input  logic                       cache_req_complete_i,
  input  tag_pkt_s                   tag_pkt_i,
  input  logic                       tag_pkt_v_i,
  output logic                       tag_pkt_ready_o,
  input  data_pkt_s                  data_pkt_i,
  input  logic                       data_pkt_v_i,
  output logic                       data_pkt_ready_o
);

  logic fetch_accept, miss_pending;
  paddr_u lookup_addr, addr_tl_r, addr_tv_r;
  logic v_tl_r, v_tv_r, tv_we;
  ptag_t [`ICACHE_WAYS-1:0] tags_tl, tags_tv_r;
  way_mask_t valid_tl, valid_tv_r, hit_v;
  dword_t [`ICACHE_WAYS-1:0] dwords_tl, dwords_tv_r;
  way_id_t hit_way, victim;
  logic hit, miss_tv;
  dword_t hit_dword;

  assign vaddr_ready_o = cache_req_ready_i & ~miss_pending;
  assign fetch_accept = vaddr_v_i & vaddr_ready_o;
  assign tag_pkt_ready_o = ~fetch_accept;
  assign data_pkt_ready_o = ~fetch_accept;

  // index and word come from the page offset, untranslated
  assign lookup_addr = {ptag_t'('0), vaddr_i[`ICACHE_PAGE_OFFSET_W-1:0]};

  icache_tag_array tags (
    .clk_i, .reset_i,
    .lookup_v_i(fetch_accept),
    .lookup_index_i(lookup_addr.cache.index),
    .tag_pkt_v_i(tag_pkt_v_i & tag_pkt_ready_o),
    .tag_pkt_i,
    .tags_o(tags_tl),
    .valid_o(valid_tl)
  );

  icache_data_banks banks (
    .clk_i,
    .lookup_v_i(fetch_accept),
    .lookup_index_i(lookup_addr.cache.index),
    .lookup_word_i(lookup_addr.cache.word),
    .data_pkt_v_i(data_pkt_v_i & data_pkt_ready_o),
    .data_pkt_i,
    .dwords_o(dwords_tl)
  );

  // TL and TV valids
  assign tv_we = v_tl_r & ptag_v_i & ~poison_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
      v_tv_r <= 1'b0;
    end else begin
      v_tl_r <= fetch_accept;
      v_tv_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_accept) begin
      addr_tl_r <= lookup_addr;
    end
    if (tv_we) begin
      addr_tv_r   <= {ptag_i, addr_tl_r.page.offset};
      tags_tv_r   <= tags_tl;
      valid_tv_r  <= valid_tl;
      dwords_tv_r <= dwords_tl;
    end
  end

  // tag compare, lowest hit way wins
  always_comb begin
    hit_way = '0;
    for (int i = `ICACHE_WAYS-1; i >= 0; i--) begin
      hit_v[i] = valid_tv_r[i] & (tags_tv_r[i] == addr_tv_r.cache.tag);
      if (hit_v[i]) begin
        hit_way = way_id_t'(i);
      end
    end
  end

  assign hit = |hit_v;
  assign miss_tv = v_tv_r & ~hit;
  assign data_v_o = v_tv_r & hit;
  assign miss_o = miss_tv | miss_pending;

  // bank holding the hit way's word, then upper or lower half
  assign hit_dword = dwords_tv_r[word_sel_t'(hit_way) ^ addr_tv_r.cache.word];
  assign data_o = addr_tv_r.cache.byte_sel[$bits(addr_tv_r.cache.byte_sel)-1]
    ? hit_dword[`ICACHE_INSTR_W+:`ICACHE_INSTR_W]
    : hit_dword[`ICACHE_INSTR_W-1:0];

  icache_plru plru (
    .clk_i, .reset_i,
    .read_index_i(addr_tl_r.cache.index),
    .update_v_i(data_v_o),
    .update_index_i(addr_tv_r.cache.index),
    .hit_way_i(hit_way),
    .valid_i(valid_tv_r),
    .victim_o(victim)
  );

  icache_miss_ctrl miss_ctrl (
    .clk_i, .reset_i,
    .miss_i(miss_tv),
    .miss_addr_i(addr_tv_r),
    .victim_i(victim),
    .cache_req_ready_i,
    .cache_req_complete_i,
    .cache_req_o,
    .cache_req_v_o,
    .cache_req_metadata_o,
    .cache_req_metadata_v_o,
    .miss_pending_o(miss_pending)
  );

  // the refill side pulses completion for a single cycle
  a_complete_pulse: assert property (
    @(posedge clk_i) disable iff (reset_i)
    cache_req_complete_i |=> !cache_req_complete_i
  );

endmodule

`default_nettype wire

/* source/icache_addr_pkg.sv */
// address types for the instruction cache
// the physical address is decoded both as page tag plus offset and as
// tag, set, word and byte
`default_nettype none

`include "icache_config.svh"

package icache_addr_pkg;

  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_id_t;
  typedef logic [$clog2(`ICACHE_SETS)-1:0] set_index_t;
  typedef logic [$clog2(`ICACHE_BLOCK_WORDS)-1:0] word_sel_t;
  typedef logic [`ICACHE_PADDR_W-`ICACHE_PAGE_OFFSET_W-1:0] ptag_t;
  typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

  // page view
  typedef struct packed {
    ptag_t                            ptag;
    logic [`ICACHE_PAGE_OFFSET_W-1:0] offset;
  } paddr_page_s;

  // cache view, byte select is within one dword
  typedef struct packed {
    ptag_t                                tag;
    set_index_t                           index;
    word_sel_t                            word;
    logic [$clog2(`ICACHE_DWORD_W/8)-1:0] byte_sel;
  } paddr_cache_s;

  typedef union packed {
    paddr_page_s  page;
    paddr_cache_s cache;
  } paddr_u;

endpackage

`default_nettype wire

/* source/icache_data_banks.sv */
// four dword banks, block words striped by way xor word
// a lookup reads one dword from every bank, so each bank returns a different way
// lookup wins over a fill, no reset on the storage
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_data_banks
  import icache_addr_pkg::*;
  import icache_fill_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      lookup_v_i,
  input  set_index_t                lookup_index_i,
  input  word_sel_t                 lookup_word_i,
  input  logic                      data_pkt_v_i,
  input  data_pkt_s                 data_pkt_i,
  output dword_t [`ICACHE_WAYS-1:0] dwords_o
);

  for (genvar b = 0; b < `ICACHE_WAYS; b++) begin : g_bank
    dword_t mem [`ICACHE_SETS*`ICACHE_BLOCK_WORDS];
    dword_t rd_r;
    word_sel_t fill_word;

    // write butterfly: bank b takes block word b ^ way at that word slot
    assign fill_word = data_pkt_i.way ^ word_sel_t'(b);

    always_ff @(posedge clk_i) begin
      if (lookup_v_i) begin
        rd_r <= mem[{lookup_index_i, lookup_word_i}];
      end else if (data_pkt_v_i) begin
        mem[{data_pkt_i.index, fill_word}] <= data_pkt_i.data[fill_word];
      end
    end

    // bank b holds way b ^ word of the looked-up slot
    assign dwords_o[b] = rd_r;
  end

endmodule

`default_nettype wire

/* source/icache_fill_pkg.sv */
// miss request, metadata and fill packet formats
// packets carry no read opcodes, so they only ever write the arrays
`default_nettype none

`include "icache_config.svh"

package icache_fill_pkg;
  import icache_addr_pkg::*;

  typedef logic [`ICACHE_DWORD_W-1:0] dword_t;
  typedef dword_t [`ICACHE_BLOCK_WORDS-1:0] block_t;

  typedef struct packed {
    paddr_u addr;
  } miss_req_s;

  typedef struct packed {
    way_id_t repl_way;
  } miss_meta_s;

  typedef enum logic [1:0] {
    e_tag_clear_set  = 2'd0,
    e_tag_invalidate = 2'd1,
    e_tag_set_tag    = 2'd2
  } tag_op_e;

  typedef struct packed {
    tag_op_e    op;
    set_index_t index;
    way_id_t    way;
    ptag_t      tag;
  } tag_pkt_s;

  typedef struct packed {
    set_index_t index;
    way_id_t    way;
    block_t     data;
  } data_pkt_s;

endpackage

`default_nettype wire

/* source/icache_miss_ctrl.sv */
// miss request, metadata one cycle later, and the outstanding-miss flag
// only one miss at a time; a second miss while pending raises no request
`timescale 1ns/1ps
`default_nettype none

module icache_miss_ctrl
  import icache_addr_pkg::*;
  import icache_fill_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       miss_i,
  input  paddr_u     miss_addr_i,
  input  way_id_t    victim_i,
  input  logic       cache_req_ready_i,
  input  logic       cache_req_complete_i,
  output miss_req_s  cache_req_o,
  output logic       cache_req_v_o,
  output miss_meta_s cache_req_metadata_o,
  output logic       cache_req_metadata_v_o,
  output logic       miss_pending_o
);

  logic pending_r;
  way_id_t repl_way_r;

  // ready is a permission, valid never waits on it
  assign cache_req_v_o = miss_i & cache_req_ready_i & ~pending_r;
  assign cache_req_o.addr = miss_addr_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r              <= 1'b0;
      cache_req_metadata_v_o <= 1'b0;
    end else begin
      cache_req_metadata_v_o <= cache_req_v_o;
      if (cache_req_v_o) begin
        pending_r <= 1'b1;
      end else if (cache_req_complete_i) begin
        pending_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_req_v_o) begin
      repl_way_r <= victim_i;
    end
  end

  assign cache_req_metadata_o.repl_way = repl_way_r;
  assign miss_pending_o = cache_req_v_o | pending_r;

  // completion only ends a miss that is outstanding
  a_complete_pending: assert property (
    @(posedge clk_i) disable iff (reset_i) cache_req_complete_i |-> pending_r
  );

endmodule

`default_nettype wire

/* source/icache_plru.sv */
// tree pseudo-LRU for 4 ways, 3 bits per set: root, left pair, right pair
// a bit of 0 points at the lower side; bits clear on reset
// a same-set hit at the read edge is forwarded into the read register
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_plru
  import icache_addr_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  set_index_t read_index_i,
  input  logic       update_v_i,
  input  set_index_t update_index_i,
  input  way_id_t    hit_way_i,
  input  way_mask_t  valid_i,
  output way_id_t    victim_o
);

  logic [`ICACHE_SETS-1:0][`ICACHE_WAYS-2:0] lru_r;
  logic [`ICACHE_WAYS-2:0] rd_r;
  logic [`ICACHE_WAYS-2:0] upd_bits;

  // point away from the accessed way
  always_comb begin
    upd_bits = lru_r[update_index_i];
    upd_bits[0] = ~hit_way_i[1];
    if (hit_way_i[1]) begin
      upd_bits[2] = ~hit_way_i[0];
    end else begin
      upd_bits[1] = ~hit_way_i[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lru_r <= '0;
      rd_r  <= '0;
    end else begin
      if (update_v_i) begin
        lru_r[update_index_i] <= upd_bits;
      end
      if (update_v_i && update_index_i == read_index_i) begin
        rd_r <= upd_bits;
      end else begin
        rd_r <= lru_r[read_index_i];
      end
    end
  end

  // lowest invalid way beats the tree
  always_comb begin
    victim_o = {rd_r[0], rd_r[0] ? rd_r[2] : rd_r[1]};
    for (int i = `ICACHE_WAYS-1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        victim_o = way_id_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

/* source/icache_tag_array.sv */
// per-set tags and valid bits
// lookup wins over a packet, the caller must hold packets off during lookups
// valid bits clear on reset, tags do not
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_tag_array
  import icache_addr_pkg::*;
  import icache_fill_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         lookup_v_i,
  input  set_index_t                   lookup_index_i,
  input  logic                         tag_pkt_v_i,
  input  tag_pkt_s                     tag_pkt_i,
  output ptag_t [`ICACHE_WAYS-1:0]     tags_o,
  output way_mask_t                    valid_o
);

  ptag_t [`ICACHE_WAYS-1:0] tag_mem [`ICACHE_SETS];
  way_mask_t [`ICACHE_SETS-1:0] valid_r;
  logic pkt_we;

  assign pkt_we = tag_pkt_v_i & ~lookup_v_i;

  // tag storage
  always_ff @(posedge clk_i) begin
    if (lookup_v_i) begin
      tags_o <= tag_mem[lookup_index_i];
    end else if (pkt_we && tag_pkt_i.op == e_tag_set_tag) begin
      tag_mem[tag_pkt_i.index][tag_pkt_i.way] <= tag_pkt_i.tag;
    end
  end

  // valid bits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
      valid_o <= '0;
    end else if (lookup_v_i) begin
      valid_o <= valid_r[lookup_index_i];
    end else if (pkt_we) begin
      case (tag_pkt_i.op)
        e_tag_clear_set: valid_r[tag_pkt_i.index] <= '0;
        e_tag_invalidate: valid_r[tag_pkt_i.index][tag_pkt_i.way] <= 1'b0;
        e_tag_set_tag: valid_r[tag_pkt_i.index][tag_pkt_i.way] <= 1'b1;
        default: valid_r <= valid_r;
      endcase
    end
  end

  // top level must drop packet valid while a fetch uses the array
  a_no_pkt_during_lookup: assert property (
    @(posedge clk_i) disable iff (reset_i) !(lookup_v_i && tag_pkt_v_i)
  );

endmodule

`default_nettype wire
